// File: hw/cdb_arbiter.sv
/*
 * CDB arbiter
 * Fixed priority, lowest station first, with a registered grant
 * and four-phase ack per station
 */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [ooo_pkg::N_STATIONS-1:0] req,
    output logic [ooo_pkg::N_STATIONS-1:0] ack,
    input  ooo_pkg::tag_t                  tags   [ooo_pkg::N_STATIONS],
    input  logic [ooo_pkg::REG_W-1:0]      rds    [ooo_pkg::N_STATIONS],
    input  logic [ooo_pkg::XLEN-1:0]       values [ooo_pkg::N_STATIONS],
    cdb_if.source                          cdb
);
    import ooo_pkg::*;

    logic [N_STATIONS-1:0] grant;  // One-hot winner this cycle
    int                    win;

    always_comb begin
        grant = '0;
        win   = 0;
        if (ack == '0) begin  // Nothing outstanding
            for (int s = N_STATIONS - 1; s >= 0; s--) begin
                if (req[s]) begin
                    grant = N_STATIONS'(1) << s;  // Lowest index ends up winning
                    win   = s;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack       <= '0;
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= |grant;               // Single-cycle broadcast
            ack       <= (ack & req) | grant;  // Ack drops after its req falls
        end
    end

    // Winner's held result onto the bus
    always_ff @(posedge clock) begin
        if (|grant) begin
            cdb.tag   <= tags[win];
            cdb.rd    <= rds[win];
            cdb.value <= values[win];
        end
    end

    // A station drops its request only after it was acknowledged
    assert property (@(posedge clock) disable iff (reset)
        ($past(req) & ~req & ~$past(ack)) == '0);

endmodule

// File: hw/cdb_if.sv
/*
 * Common data bus and station dispatch interfaces
 */
`timescale 1ns/1ps

interface cdb_if;
    import ooo_pkg::*;

    logic             valid;  // One cycle per result
    tag_t             tag;    // Producer of this value
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  value;

    modport source   (output valid, tag, rd, value);
    modport listener (input valid, tag, rd, value);
endinterface

interface dispatch_if;
    import ooo_pkg::*;

    logic             valid;  // One cycle, only while busy is low
    opcode_t          op;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  vj;
    logic [XLEN-1:0]  vk;
    tag_t             qj;     // Pending producer of vj
    tag_t             qk;     // Pending producer of vk
    tag_t             tag;    // Selects the station entry
    logic             busy;   // All entries allocated

    modport issuer  (output valid, op, rd, vj, vk, qj, qk, tag, input busy);
    modport station (input valid, op, rd, vj, vk, qj, qk, tag, output busy);
endinterface

// File: hw/exec_station.sv
/*
 * Execution station
 * Reservation entries with CDB wakeup, oldest-ready issue into a
 * LATENCY-deep functional unit, result hold with four-phase request
 */
`timescale 1ns/1ps

module exec_station #(
    parameter int DEPTH      = 2,
    parameter int LATENCY    = 1,
    parameter int STATION_ID = 0
) (
    input  logic                      clock,
    input  logic                      reset,
    dispatch_if.station               disp,
    cdb_if.listener                   cdb,
    output logic                      res_req,
    input  logic                      res_ack,
    output ooo_pkg::tag_t             res_tag,
    output logic [ooo_pkg::REG_W-1:0] res_rd,
    output logic [ooo_pkg::XLEN-1:0]  res_value
);
    import ooo_pkg::*;

    localparam int BASE  = 1 + STATION_ID * DEPTH;  // Tag of entry 0
    localparam int AGE_W = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0] alloc;        // Held until result acknowledged
    logic [DEPTH-1:0] issued;
    logic [DEPTH-1:0] wr;           // Dispatch lands in this entry
    opcode_t          e_op  [DEPTH];
    logic [REG_W-1:0] e_rd  [DEPTH];
    logic [XLEN-1:0]  e_vj  [DEPTH];
    logic [XLEN-1:0]  e_vk  [DEPTH];
    tag_t             e_qj  [DEPTH];
    tag_t             e_qk  [DEPTH];
    logic [AGE_W-1:0] e_age [DEPTH];  // Larger is older

    logic [LATENCY-1:0] p_valid;
    logic [LATENCY-1:0] p_open;     // Stage can take new data this cycle
    tag_t               p_tag [LATENCY];
    logic [REG_W-1:0]   p_rd  [LATENCY];
    logic [XLEN-1:0]    p_val [LATENCY];

    logic            hold_take;     // Result hold free and ack low
    logic            issue;
    int              sel;
    logic [XLEN-1:0] fu_result;

    assign disp.busy = &alloc;

    ////////////////////////////////////////////////////////////////////////////
    // Select and evaluate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hold_take         = !res_req && !res_ack;
        p_open[LATENCY-1] = !p_valid[LATENCY-1] || hold_take;
        for (int s = LATENCY - 2; s >= 0; s--)
            p_open[s] = !p_valid[s] || p_open[s+1];  // Bubbles collapse
        issue = 1'b0;
        sel   = 0;
        for (int e = 0; e < DEPTH; e++) begin
            wr[e] = disp.valid && (int'(disp.tag) - BASE == e);
            if (alloc[e] && !issued[e] && e_qj[e] == '0 && e_qk[e] == '0 &&
                (!issue || e_age[e] > e_age[sel])) begin
                issue = 1'b1;
                sel   = e;
            end
        end
        issue = issue && p_open[0];  // Full pipeline stops issue
        case (e_op[sel])
            OP_SUB:  fu_result = e_vj[sel] - e_vk[sel];
            OP_AND:  fu_result = e_vj[sel] & e_vk[sel];
            OP_XOR:  fu_result = e_vj[sel] ^ e_vk[sel];
            OP_MUL:  fu_result = e_vj[sel] * e_vk[sel];  // Low half of product
            default: fu_result = e_vj[sel] + e_vk[sel];  // ADD and ADDI
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reservation entries
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            alloc  <= '0;
            issued <= '0;
        end else begin
            for (int e = 0; e < DEPTH; e++) begin
                if (res_req && res_ack && int'(res_tag) - BASE == e) begin
                    alloc[e]  <= 1'b0;
                    issued[e] <= 1'b0;
                end
                if (wr[e])
                    alloc[e] <= 1'b1;
            end
            if (issue)
                issued[sel] <= 1'b1;
        end
    end

    // Operand capture, from dispatch or from a matching broadcast
    always_ff @(posedge clock) begin
        for (int e = 0; e < DEPTH; e++) begin
            if (wr[e]) begin
                e_op[e]  <= disp.op;
                e_rd[e]  <= disp.rd;
                e_vj[e]  <= disp.vj;
                e_vk[e]  <= disp.vk;
                e_qj[e]  <= disp.qj;
                e_qk[e]  <= disp.qk;
                e_age[e] <= '0;
            end else if (disp.valid && alloc[e]) begin
                e_age[e] <= e_age[e] + 1'b1;
            end
            // Producer may broadcast in the same cycle the entry is written
            if (cdb.valid && cdb.tag == (wr[e] ? disp.qj : e_qj[e])) begin
                e_vj[e] <= cdb.value;
                e_qj[e] <= '0;
            end
            if (cdb.valid && cdb.tag == (wr[e] ? disp.qk : e_qk[e])) begin
                e_vk[e] <= cdb.value;
                e_qk[e] <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Functional unit pipeline and result hold
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            p_valid <= '0;
            res_req <= 1'b0;
        end else begin
            if (p_open[0])
                p_valid[0] <= issue;
            for (int s = 1; s < LATENCY; s++) begin
                if (p_open[s])
                    p_valid[s] <= p_valid[s-1];
            end
            if (res_req && res_ack)
                res_req <= 1'b0;                  // Third phase
            else if (hold_take && p_valid[LATENCY-1])
                res_req <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (p_open[0]) begin
            p_tag[0] <= tag_t'(BASE + sel);
            p_rd[0]  <= e_rd[sel];
            p_val[0] <= fu_result;
        end
        for (int s = 1; s < LATENCY; s++) begin
            if (p_open[s]) begin
                p_tag[s] <= p_tag[s-1];
                p_rd[s]  <= p_rd[s-1];
                p_val[s] <= p_val[s-1];
            end
        end
        if (hold_take && p_valid[LATENCY-1]) begin
            res_tag   <= p_tag[LATENCY-1];
            res_rd    <= p_rd[LATENCY-1];
            res_value <= p_val[LATENCY-1];
        end
    end

    // Arbiter lets ack go once the request is down
    assert property (@(posedge clock) disable iff (reset)
        !res_req && res_ack |=> !res_ack);

endmodule

// File: hw/issue_unit.sv
/*
 * Issue unit
 * Decodes one instruction per four-phase handshake, reads operands from
 * the register file or renames them to producer tags, and dispatches
 */
`timescale 1ns/1ps

module issue_unit #(
    parameter int DEPTH = 2
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           insn_req,
    input  ooo_pkg::insn_t insn,
    output logic           insn_ack,
    cdb_if.listener        cdb,
    dispatch_if.issuer     alu_disp,
    dispatch_if.issuer     mul_disp
);
    import ooo_pkg::*;

    localparam int N_TAGS = N_STATIONS * DEPTH;

    logic [XLEN-1:0]   rf   [2**REG_W];  // Architectural registers
    tag_t              stat [2**REG_W];  // Newest producer per register
    logic [N_TAGS-1:0] used;             // Entry allocation, bit = tag - 1

    opcode_t          op;
    logic             to_mul;
    logic             go;        // Dispatch this cycle
    int               base;      // First tag index of the target station
    tag_t             new_tag;
    logic [XLEN-1:0]  src1_val;
    logic [XLEN-1:0]  src2_val;
    tag_t             src1_tag;
    tag_t             src2_tag;

    // Register value, producer tag, or the broadcast happening right now
    function automatic void read_src(input logic [REG_W-1:0] rs,
                                     output logic [XLEN-1:0] val,
                                     output tag_t tag);
        val = rf[rs];
        tag = stat[rs];
        if (tag != '0 && cdb.valid && cdb.tag == tag) begin
            val = cdb.value;
            tag = '0;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Decode and rename
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        op     = insn.r.op;
        to_mul = (op == OP_MUL);
        go     = insn_req && !insn_ack && !(to_mul ? mul_disp.busy : alu_disp.busy);
        read_src(insn.r.rs1, src1_val, src1_tag);
        read_src(insn.r.rs2, src2_val, src2_tag);
        if (op == OP_ADDI) begin
            src2_val = {{(XLEN-7){insn.i.imm[6]}}, insn.i.imm};  // Sign extend
            src2_tag = '0;
        end
        // Lowest free entry of the target station
        base    = (to_mul ? MUL_STATION : ALU_STATION) * DEPTH;
        new_tag = '0;
        for (int e = DEPTH - 1; e >= 0; e--) begin
            if (!used[base + e])
                new_tag = tag_t'(base + e + 1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Handshake, register file, status table
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            insn_ack       <= 1'b0;
            alu_disp.valid <= 1'b0;
            mul_disp.valid <= 1'b0;
            used           <= '0;
            for (int r = 0; r < 2**REG_W; r++) begin
                rf[r]   <= '0;
                stat[r] <= '0;
            end
        end else begin
            alu_disp.valid <= go && !to_mul;  // Single pulse
            mul_disp.valid <= go && to_mul;
            if (go)
                insn_ack <= 1'b1;
            else if (!insn_req)
                insn_ack <= 1'b0;             // Fourth phase
            if (cdb.valid) begin
                used[int'(cdb.tag) - 1] <= 1'b0;      // Entry released by station too
                if (stat[cdb.rd] == cdb.tag) begin    // Still newest writer
                    rf[cdb.rd]   <= cdb.value;
                    stat[cdb.rd] <= '0;
                end
            end
            if (go) begin
                used[int'(new_tag) - 1] <= 1'b1;
                if (insn.r.rd != '0)
                    stat[insn.r.rd] <= new_tag;       // Overrides a same-cycle clear
            end
        end
    end

    // Dispatch payload, shared by both stations
    always_ff @(posedge clock) begin
        if (go) begin
            alu_disp.op  <= op;
            alu_disp.rd  <= insn.r.rd;
            alu_disp.vj  <= src1_val;
            alu_disp.vk  <= src2_val;
            alu_disp.qj  <= src1_tag;
            alu_disp.qk  <= src2_tag;
            alu_disp.tag <= new_tag;
            mul_disp.op  <= op;
            mul_disp.rd  <= insn.r.rd;
            mul_disp.vj  <= src1_val;
            mul_disp.vk  <= src2_val;
            mul_disp.qj  <= src1_tag;
            mul_disp.qk  <= src2_tag;
            mul_disp.tag <= new_tag;
        end
    end

    // Station must still have a free entry when the pulse lands
    assert property (@(posedge clock) disable iff (reset)
        (alu_disp.valid -> !alu_disp.busy) && (mul_disp.valid -> !mul_disp.busy));

    // Every broadcast comes from an entry this unit allocated
    assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (cdb.tag != '0 && used[int'(cdb.tag) - 1]));

endmodule

// File: hw/ooo_core.sv
/*
 * Out-of-order issue core, top level
 * Issue unit, ALU and multiplier stations, CDB arbiter
 */
`timescale 1ns/1ps

module ooo_core #(
    parameter int DEPTH       = 2,  // Entries per station
    parameter int ALU_LATENCY = 1,
    parameter int MUL_LATENCY = 3
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      insn_req,
    input  ooo_pkg::insn_t            insn,
    output logic                      insn_ack,
    output logic                      commit_valid,
    output logic [ooo_pkg::REG_W-1:0] commit_rd,
    output logic [ooo_pkg::XLEN-1:0]  commit_value
);
    import ooo_pkg::*;

    cdb_if      cdb ();
    dispatch_if alu_disp ();
    dispatch_if mul_disp ();

    // Station results towards the arbiter
    logic [N_STATIONS-1:0] res_req;
    logic [N_STATIONS-1:0] res_ack;
    tag_t                  res_tag   [N_STATIONS];
    logic [REG_W-1:0]      res_rd    [N_STATIONS];
    logic [XLEN-1:0]       res_value [N_STATIONS];

    issue_unit #(.DEPTH(DEPTH)) issue_unit_inst (
        .clock    (clock),
        .reset    (reset),
        .insn_req (insn_req),
        .insn     (insn),
        .insn_ack (insn_ack),
        .cdb      (cdb),
        .alu_disp (alu_disp),
        .mul_disp (mul_disp)
    );

    exec_station #(
        .DEPTH      (DEPTH),
        .LATENCY    (ALU_LATENCY),
        .STATION_ID (ALU_STATION)
    ) alu_station_inst (
        .clock     (clock),
        .reset     (reset),
        .disp      (alu_disp),
        .cdb       (cdb),
        .res_req   (res_req[ALU_STATION]),
        .res_ack   (res_ack[ALU_STATION]),
        .res_tag   (res_tag[ALU_STATION]),
        .res_rd    (res_rd[ALU_STATION]),
        .res_value (res_value[ALU_STATION])
    );

    exec_station #(
        .DEPTH      (DEPTH),
        .LATENCY    (MUL_LATENCY),
        .STATION_ID (MUL_STATION)
    ) mul_station_inst (
        .clock     (clock),
        .reset     (reset),
        .disp      (mul_disp),
        .cdb       (cdb),
        .res_req   (res_req[MUL_STATION]),
        .res_ack   (res_ack[MUL_STATION]),
        .res_tag   (res_tag[MUL_STATION]),
        .res_rd    (res_rd[MUL_STATION]),
        .res_value (res_value[MUL_STATION])
    );

    cdb_arbiter cdb_arbiter_inst (
        .clock  (clock),
        .reset  (reset),
        .req    (res_req),
        .ack    (res_ack),
        .tags   (res_tag),
        .rds    (res_rd),
        .values (res_value),
        .cdb    (cdb)
    );

    // Every broadcast is a commit, in completion order
    assign commit_valid = cdb.valid;
    assign commit_rd    = cdb.rd;
    assign commit_value = cdb.value;

endmodule

// File: hw/ooo_pkg.sv
/*
 * Shared definitions for the out-of-order issue core
 * Data and register widths, opcodes, producer tags and the
 * instruction word with its register and immediate forms
 */
package ooo_pkg;

    localparam int XLEN       = 16;  // Data width
    localparam int REG_W      = 3;   // 8 registers, r0 reads zero
    localparam int TAG_W      = 3;   // Producer tag width
    localparam int N_STATIONS = 2;

    // Station indices, also arbiter priority order
    localparam int ALU_STATION = 0;
    localparam int MUL_STATION = 1;

    // Zero means operand ready, else 1 + station * DEPTH + entry
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADDI = 3'd4,  // Only user of the immediate form
        OP_MUL  = 3'd5
    } opcode_t;

    // Register form
    typedef struct packed {
        opcode_t          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [3:0]       unused;
    } insn_reg_t;

    // Immediate form
    typedef struct packed {
        opcode_t          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [6:0]       imm;     // Signed
    } insn_imm_t;

    // Same 16 bits, decoded by opcode
    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_t;

endpackage

// File: ooo_core.f
hw/ooo_pkg.sv
hw/cdb_if.sv
hw/issue_unit.sv
hw/exec_station.sv
hw/cdb_arbiter.sv
hw/ooo_core.sv
testbench/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb -f ooo_core.f -o ooo_core_sim

./obj_dir/ooo_core_sim > sim.log 2>&1
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: testbench/ooo_core_tb.sv
/*
 * Testbench for the out-of-order issue core
 * Sends pattern-file instructions over the four-phase port and
 * matches every commit against an expected destination and value
 */
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int MAX_PATS       = 32;
    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_PAT = 40;  // Watchdog budget per instruction

    logic             clock;
    logic             reset;
    logic             insn_req;
    insn_t            insn;
    logic             insn_ack;
    logic             commit_valid;
    logic [REG_W-1:0] commit_rd;
    logic [XLEN-1:0]  commit_value;

    logic [15:0]         pat_mem [3*MAX_PATS+1];  // Count, then insn/rd/value triples
    logic [MAX_PATS-1:0] matched;                 // Pattern already committed
    int                  n_pats;
    int                  commit_count;
    int                  value_errors;
    int                  missing_errors;
    int                  other_errors;
    logic [31:0]         rng_state;

    ooo_core ooo_core_inst (
        .clock        (clock),
        .reset        (reset),
        .insn_req     (insn_req),
        .insn         (insn),
        .insn_ack     (insn_ack),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Index plus opcode, e.g. insn9_OP_MUL
    function automatic string pat_name(input int idx);
        opcode_t op;
        op = opcode_t'(pat_mem[3*idx+1][15:13]);
        return $sformatf("insn%0d_%s", idx, op.name());
    endfunction

    task automatic check_idle(input string when);
        if (insn_ack !== 1'b0 || commit_valid !== 1'b0) begin
            other_errors++;
            $display("insn_ack or commit_valid is not low %s", when);
        end
    endtask

    // One full four-phase transfer
    task automatic send_insn(input logic [15:0] word);
        @(posedge clock);
        insn     <= insn_t'(word);
        insn_req <= 1'b1;
        @(negedge clock);
        while (!insn_ack) @(negedge clock);  // Longer under back-pressure
        @(posedge clock);
        insn_req <= 1'b0;
        @(negedge clock);
        while (insn_ack) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Commit matching, mid-cycle sample
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin : commit_monitor
        int hit;
        int same_rd;
        if (!reset && commit_valid) begin
            commit_count++;
            hit     = -1;
            same_rd = -1;
            for (int i = 0; i < n_pats; i++) begin
                if (!matched[i] && pat_mem[3*i+2] == 16'(commit_rd)) begin
                    if (same_rd < 0)
                        same_rd = i;  // First open entry for this register
                    if (hit < 0 && pat_mem[3*i+3] == commit_value)
                        hit = i;
                end
            end
            if (hit >= 0) begin
                matched[hit] = 1'b1;
            end else if (same_rd >= 0) begin
                value_errors++;
                $display("Fail %s: expected r%0d = %h, actual %h", pat_name(same_rd),
                         commit_rd, pat_mem[3*same_rd+3], commit_value);
            end else begin
                other_errors++;
                $display("Unexpected commit to r%0d with value %h", commit_rd, commit_value);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and final report
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset          = 1'b1;
        insn_req       = 1'b0;
        insn           = '0;
        matched        = '0;
        commit_count   = 0;
        value_errors   = 0;
        missing_errors = 0;
        other_errors   = 0;
        rng_state      = 32'd44;  // Seed
        $readmemh("testbench/ooo_patterns.txt", pat_mem);
        n_pats = int'(pat_mem[0]);
        if (n_pats > MAX_PATS) begin
            other_errors++;
            $display("Pattern file lists more instructions than the testbench holds");
            n_pats = 0;
        end

        repeat (RESET_CYCLES - 1) begin
            @(negedge clock);
            check_idle("during reset");
        end
        @(posedge clock);
        reset <= 1'b0;  // Fourth reset edge
        repeat (2) begin
            @(negedge clock);
            check_idle("right after reset");
        end

        for (int i = 0; i < n_pats; i++) begin
            send_insn(pat_mem[3*i+1]);
            rng_state = xorshift32(rng_state);
            repeat (rng_state[1:0]) @(posedge clock);  // Gap of 0 to 3 cycles
        end

        while (commit_count < n_pats) @(negedge clock);
        repeat (20) @(negedge clock);  // Room for stray extra commits

        for (int i = 0; i < n_pats; i++) begin
            if (!matched[i]) begin
                missing_errors++;
                $display("No matching commit seen for %s", pat_name(i));
            end
        end
        if (commit_count != n_pats) begin
            other_errors++;
            $display("Saw %0d commits for %0d instructions", commit_count, n_pats);
        end

        $display("Errors: %0d wrong values, %0d missing commits, %0d other",
                 value_errors, missing_errors, other_errors);
        if (value_errors + missing_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, sized by the pattern count
    initial begin : watchdog
        @(negedge clock);
        repeat (RESET_CYCLES + 20 + n_pats * CYCLES_PER_PAT) @(posedge clock);
        $display("Watchdog timeout with %0d of %0d commits seen", commit_count, n_pats);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: testbench/ooo_patterns.txt
// Columns: instruction word, expected rd, expected value (hex)
// First word is the instruction count, also hex
16
8405 1 0005  // ADDI r1, r0, 5
0890 2 000a  // ADD  r2, r1, r1     chain through tag wakeup
6d10 3 000f  // XOR  r3, r2, r1
947d 5 fffd  // ADDI r5, r0, -3
980c 6 000c  // ADDI r6, r0, 12
3f10 7 0007  // SUB  r7, r6, r1
4b30 2 000c  // AND  r2, r6, r3
6ee0 3 fff1  // XOR  r3, r5, r6
b310 4 003c  // MUL  r4, r6, r1
1e20 7 0048  // ADD  r7, r4, r2
b6e0 5 ffdc  // MUL  r5, r5, r6     negative times positive
27e0 1 003c  // SUB  r1, r7, r6
b3f0 4 1440  // MUL  r4, r7, r7     renamed away by the next ADDI
9021 4 0021  // ADDI r4, r0, 33
1a10 6 005d  // ADD  r6, r4, r1     must see the ADDI value
8803 2 0003  // ADDI r2, r0, 3
ad20 3 0009  // MUL  r3, r2, r2     burst of dependent MULs
ada0 3 001b  // MUL  r3, r3, r2
ada0 3 0051  // MUL  r3, r3, r2
ada0 3 00f3  // MUL  r3, r3, r2
ada0 3 02d9  // MUL  r3, r3, r2
1dd0 7 02b5  // ADD  r7, r3, r5
